// File: Makefile
bin := obj_dir/Vissue_unit_tb

.PHONY: run clean

run: $(bin)
	@out=$$(./$(bin)); \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

$(bin): src.f $(wildcard design/*.sv dv/*.sv)
	verilator --binary --timing -Wno-fatal --top-module issue_unit_tb -f src.f

clean:
	rm -rf obj_dir

// File: design/issue_ctrl.sv
`timescale 1ns/1ns

module issue_ctrl #(
    parameter int rob_depth  = 8,
    parameter int rs_credits = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         issue_valid,
    input  logic                         credit_return,
    input  logic                         flush,
    input  logic                         head_done,
    input  rename_pkg::op_kind_e         issue_kind,
    output logic                         issue_ready,
    output logic                         alloc_en,
    output logic [rename_pkg::tag_w-1:0] alloc_tag,
    output logic                         rename_en,
    output logic                         commit_en,
    output logic                         flush_clear,
    output logic [rename_pkg::tag_w-1:0] head_tag
);

    localparam int tw       = rename_pkg::tag_w;
    localparam int count_w  = tw + 1;
    localparam int credit_w = $clog2(rs_credits + 1);
    localparam logic [tw-1:0]      last_tag = tw'(rob_depth - 1);
    localparam logic [count_w-1:0] full_cnt = count_w'(rob_depth);

    logic [credit_w-1:0] credit_q;
    logic [count_w-1:0]  count_q;
    logic [tw-1:0]       head_q;
    logic [tw-1:0]       tail_q;

    // wrap at rob_depth, not at the tag width
    function automatic logic [tw-1:0] next_tag(input logic [tw-1:0] t);
        return (t == last_tag) ? '0 : t + 1'b1;
    endfunction

    // ##############################
    // accept and retire
    // ##############################

    assign issue_ready = (credit_q != '0) && (count_q != full_cnt) && !flush;
    assign alloc_en    = issue_valid && issue_ready;
    assign rename_en   = alloc_en && (issue_kind == rename_pkg::op_alu ||
                                      issue_kind == rename_pkg::op_load);
    // stale done bits linger in an empty buffer
    assign commit_en   = head_done && (count_q != '0) && !flush;
    assign flush_clear = flush;
    assign alloc_tag   = tail_q;
    assign head_tag    = head_q;

    // credits survive a flush because the station still hands them back
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_q <= credit_w'(rs_credits);
        end else if (alloc_en && !credit_return) begin
            credit_q <= credit_q - 1'b1;
        end else if (credit_return && !alloc_en) begin
            credit_q <= credit_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_en) begin
                tail_q <= next_tag(tail_q);
            end
            if (commit_en) begin
                head_q <= next_tag(head_q);
            end
            case ({alloc_en, commit_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// File: design/issue_unit.sv
`timescale 1ns/1ns

module issue_unit #(
    parameter int rob_depth  = 8,
    parameter int rs_credits = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue_valid,
    input  rename_pkg::issue_req_t issue_req,
    output logic                   issue_ready,
    output logic                   dispatch_valid,
    output rename_pkg::dispatch_t  dispatch,
    input  logic                   credit_return,
    input  logic                   result_valid,
    input  rename_pkg::result_t    result,
    output logic                   commit_valid,
    output rename_pkg::commit_t    commit,
    input  logic                   flush
);

    logic                              alloc_en;
    logic [rename_pkg::tag_w-1:0]      alloc_tag;
    logic                              rename_en;
    logic                              commit_en;
    logic                              flush_clear;
    logic [rename_pkg::tag_w-1:0]      head_tag;
    logic                              head_done;
    logic [rename_pkg::reg_addr_w-1:0] head_rd;
    logic [rename_pkg::data_w-1:0]     head_data;
    logic [rename_pkg::tag_w-1:0]      src1_tag;
    logic [rename_pkg::tag_w-1:0]      src2_tag;
    logic                              src1_done;
    logic                              src2_done;
    logic [rename_pkg::data_w-1:0]     src1_value;
    logic [rename_pkg::data_w-1:0]     src2_value;
    rename_pkg::operand_t              src1;
    rename_pkg::operand_t              src2;

    issue_ctrl #(
        .rob_depth  (rob_depth),
        .rs_credits (rs_credits)
    ) issue_ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .issue_valid   (issue_valid),
        .credit_return (credit_return),
        .flush         (flush),
        .head_done     (head_done),
        .issue_kind    (issue_req.kind),
        .issue_ready   (issue_ready),
        .alloc_en      (alloc_en),
        .alloc_tag     (alloc_tag),
        .rename_en     (rename_en),
        .commit_en     (commit_en),
        .flush_clear   (flush_clear),
        .head_tag      (head_tag)
    );

    rename_regfile rename_regfile_i (
        .clk         (clk),
        .rst         (rst),
        .rename_en   (rename_en),
        .alloc_tag   (alloc_tag),
        .issue_req   (issue_req),
        .commit_en   (commit_en),
        .head_rd     (head_rd),
        .head_data   (head_data),
        .head_tag    (head_tag),
        .flush_clear (flush_clear),
        .src1_done   (src1_done),
        .src1_value  (src1_value),
        .src2_done   (src2_done),
        .src2_value  (src2_value),
        .src1_tag    (src1_tag),
        .src2_tag    (src2_tag),
        .src1        (src1),
        .src2        (src2)
    );

    reorder_buffer #(
        .rob_depth (rob_depth)
    ) reorder_buffer_i (
        .clk          (clk),
        .rst          (rst),
        .alloc_en     (alloc_en),
        .alloc_tag    (alloc_tag),
        .alloc_rd     (issue_req.rd),
        .result_valid (result_valid),
        .result       (result),
        .head_tag     (head_tag),
        .flush_clear  (flush_clear),
        .src1_tag     (src1_tag),
        .src2_tag     (src2_tag),
        .head_done    (head_done),
        .head_rd      (head_rd),
        .head_data    (head_data),
        .src1_done    (src1_done),
        .src1_value   (src1_value),
        .src2_done    (src2_done),
        .src2_value   (src2_value)
    );

    // ##############################
    // dispatch register
    // ##############################

    always_ff @(posedge clk) begin
        if (rst) begin
            dispatch_valid <= 1'b0;
        end else begin
            dispatch_valid <= alloc_en;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            dispatch.kind     <= issue_req.kind;
            dispatch.dest_tag <= alloc_tag;
            dispatch.rd       <= issue_req.rd;
            dispatch.src1     <= src1;
            dispatch.src2     <= src2;
            dispatch.imm      <= issue_req.imm;
            dispatch.pc       <= issue_req.pc;
        end
    end

    // retirement goes out in the same cycle the head turns done
    assign commit_valid = commit_en;
    assign commit.rd    = commit_en ? head_rd : '0;
    assign commit.data  = commit_en ? head_data : '0;

endmodule

// File: design/rename_pkg.sv
package rename_pkg;

    // ##############################
    // widths
    // ##############################

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    // caps the reorder buffer at 8 entries
    localparam int tag_w      = 3;

    // only alu and load ops write rd
    typedef enum logic [1:0] {
        op_alu,
        op_load,
        op_store,
        op_branch
    } op_kind_e;

    // ##############################
    // operand word
    // ##############################

    // value when ready, producer tag when pending
    typedef union packed {
        logic [data_w-1:0] value;
        struct packed {
            logic [data_w-tag_w-1:0] pad;
            logic [tag_w-1:0]        tag;
        } pend;
    } operand_u;

    typedef struct packed {
        logic     ready;
        operand_u word;
    } operand_t;

    // ##############################
    // packets
    // ##############################

    typedef struct packed {
        op_kind_e              kind;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [data_w-1:0]     imm;
        logic [data_w-1:0]     pc;
    } issue_req_t;

    typedef struct packed {
        op_kind_e              kind;
        logic [tag_w-1:0]      dest_tag;
        logic [reg_addr_w-1:0] rd;
        operand_t              src1;
        operand_t              src2;
        logic [data_w-1:0]     imm;
        logic [data_w-1:0]     pc;
    } dispatch_t;

    typedef struct packed {
        logic [tag_w-1:0]  tag;
        logic [data_w-1:0] data;
    } result_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] rd;
        logic [data_w-1:0]     data;
    } commit_t;

endpackage

// File: design/rename_regfile.sv
`timescale 1ns/1ns

module rename_regfile (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rename_en,
    input  logic [rename_pkg::tag_w-1:0]      alloc_tag,
    input  rename_pkg::issue_req_t            issue_req,
    input  logic                              commit_en,
    input  logic [rename_pkg::reg_addr_w-1:0] head_rd,
    input  logic [rename_pkg::data_w-1:0]     head_data,
    input  logic [rename_pkg::tag_w-1:0]      head_tag,
    input  logic                              flush_clear,
    input  logic                              src1_done,
    input  logic [rename_pkg::data_w-1:0]     src1_value,
    input  logic                              src2_done,
    input  logic [rename_pkg::data_w-1:0]     src2_value,
    output logic [rename_pkg::tag_w-1:0]      src1_tag,
    output logic [rename_pkg::tag_w-1:0]      src2_tag,
    output rename_pkg::operand_t              src1,
    output rename_pkg::operand_t              src2
);

    localparam int dw       = rename_pkg::data_w;
    localparam int tw       = rename_pkg::tag_w;
    localparam int num_regs = 2 ** rename_pkg::reg_addr_w;

    logic [dw-1:0]       data_q [num_regs];
    logic [tw-1:0]       tag_q  [num_regs];
    logic [num_regs-1:0] pend_q;

    logic commit_wr;
    logic cmt_hit1;
    logic cmt_hit2;

    // settled data first, then same-cycle commit, then finished rob entry
    function automatic rename_pkg::operand_t lookup(
        input logic          pend,
        input logic [tw-1:0] tag,
        input logic [dw-1:0] data,
        input logic          cmt_hit,
        input logic [dw-1:0] cmt_data,
        input logic          done,
        input logic [dw-1:0] value
    );
        rename_pkg::operand_t op;
        op.ready = 1'b1;
        if (!pend) begin
            op.word.value = data;
        end else if (cmt_hit) begin
            op.word.value = cmt_data;
        end else if (done) begin
            op.word.value = value;
        end else begin
            op.ready         = 1'b0;
            op.word.pend.pad = '0;
            op.word.pend.tag = tag;
        end
        return op;
    endfunction

    // ##############################
    // operand lookup
    // ##############################

    assign src1_tag = tag_q[issue_req.rs1];
    assign src2_tag = tag_q[issue_req.rs2];

    assign cmt_hit1 = commit_en && (head_rd == issue_req.rs1) && (head_tag == src1_tag);
    assign cmt_hit2 = commit_en && (head_rd == issue_req.rs2) && (head_tag == src2_tag);

    // x0 is never pending and its data stays zero
    assign src1 = lookup(pend_q[issue_req.rs1], src1_tag, data_q[issue_req.rs1],
                         cmt_hit1, head_data, src1_done, src1_value);
    assign src2 = lookup(pend_q[issue_req.rs2], src2_tag, data_q[issue_req.rs2],
                         cmt_hit2, head_data, src2_done, src2_value);

    // ##############################
    // updates
    // ##############################

    assign commit_wr = commit_en && (head_rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                data_q[i] <= '0;
            end
        end else if (commit_wr) begin
            data_q[head_rd] <= head_data;
        end
    end

    // rename is applied last so it beats a matching commit
    always_ff @(posedge clk) begin
        if (rst || flush_clear) begin
            pend_q <= '0;
        end else begin
            if (commit_wr && tag_q[head_rd] == head_tag) begin
                pend_q[head_rd] <= 1'b0;
            end
            if (rename_en && issue_req.rd != '0) begin
                pend_q[issue_req.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rename_en) begin
            tag_q[issue_req.rd] <= alloc_tag;
        end
    end

endmodule

// File: design/reorder_buffer.sv
`timescale 1ns/1ns

module reorder_buffer #(
    parameter int rob_depth = 8
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              alloc_en,
    input  logic [rename_pkg::tag_w-1:0]      alloc_tag,
    input  logic [rename_pkg::reg_addr_w-1:0] alloc_rd,
    input  logic                              result_valid,
    input  rename_pkg::result_t               result,
    input  logic [rename_pkg::tag_w-1:0]      head_tag,
    input  logic                              flush_clear,
    input  logic [rename_pkg::tag_w-1:0]      src1_tag,
    input  logic [rename_pkg::tag_w-1:0]      src2_tag,
    output logic                              head_done,
    output logic [rename_pkg::reg_addr_w-1:0] head_rd,
    output logic [rename_pkg::data_w-1:0]     head_data,
    output logic                              src1_done,
    output logic [rename_pkg::data_w-1:0]     src1_value,
    output logic                              src2_done,
    output logic [rename_pkg::data_w-1:0]     src2_value
);

    localparam int dw = rename_pkg::data_w;
    localparam int aw = rename_pkg::reg_addr_w;

    logic [rob_depth-1:0] done_q;
    logic [aw-1:0]        rd_q    [rob_depth];
    logic [dw-1:0]        value_q [rob_depth];

    // ##############################
    // entry state
    // ##############################

    always_ff @(posedge clk) begin
        if (rst || flush_clear) begin
            done_q <= '0;
        end else begin
            if (alloc_en) begin
                done_q[alloc_tag] <= 1'b0;
            end
            // env only returns live tags, never the one being allocated
            if (result_valid) begin
                done_q[result.tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            rd_q[alloc_tag] <= alloc_rd;
        end
        if (result_valid) begin
            value_q[result.tag] <= result.data;
        end
    end

    // ##############################
    // read ports
    // ##############################

    assign head_done  = done_q[head_tag];
    assign head_rd    = rd_q[head_tag];
    assign head_data  = value_q[head_tag];

    // completion forwarding for operands still marked pending
    assign src1_done  = done_q[src1_tag];
    assign src1_value = value_q[src1_tag];
    assign src2_done  = done_q[src2_tag];
    assign src2_value = value_q[src2_tag];

endmodule

// File: dv/issue_unit_tb.sv
`timescale 1ns/1ns

module issue_unit_tb;

    localparam int rob_depth  = 8;
    localparam int rs_credits = 4;
    localparam int wait_limit = 200;

    logic                   clk;
    logic                   rst;
    logic                   issue_valid;
    rename_pkg::issue_req_t issue_req;
    logic                   issue_ready;
    logic                   dispatch_valid;
    rename_pkg::dispatch_t  dispatch;
    logic                   credit_return;
    logic                   result_valid;
    rename_pkg::result_t    result;
    logic                   commit_valid;
    rename_pkg::commit_t    commit;
    logic                   flush;

    // accepted requests, in program order, for the dispatch fields
    rename_pkg::issue_req_t issued_q [$];
    rename_pkg::dispatch_t  dispatch_seen [$];
    rename_pkg::commit_t    commit_seen [$];

    int seed = 30726;
    int passed;
    int failed;
    int test_num;
    bit timed_out;

    issue_unit #(
        .rob_depth  (rob_depth),
        .rs_credits (rs_credits)
    ) issue_unit_i (
        .clk            (clk),
        .rst            (rst),
        .issue_valid    (issue_valid),
        .issue_req      (issue_req),
        .issue_ready    (issue_ready),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .credit_return  (credit_return),
        .result_valid   (result_valid),
        .result         (result),
        .commit_valid   (commit_valid),
        .commit         (commit),
        .flush          (flush)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // sampled mid-cycle
    always @(negedge clk) begin
        if (dispatch_valid) begin
            dispatch_seen.push_back(dispatch);
        end
        if (commit_valid) begin
            commit_seen.push_back(commit);
        end
    end

    // ##############################
    // checks
    // ##############################

    task automatic check_field(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual,
                               inout bit ok);
        assert (expected === actual) else begin
            $display("ERROR %s %s: expected %h, actual %h", name, field, expected, actual);
            ok = 1'b0;
        end
    endtask

    task automatic finish_test(input string name, input bit ok);
        if (ok) begin
            passed++;
            $display("PASS %s", name);
        end else begin
            failed++;
            $display("FAIL %s", name);
        end
    endtask

    // pending operands carry the producer tag in the low bits over a zero pad
    task automatic check_operand(input string name, input string label, input logic rdy,
                                 input logic [31:0] word, input rename_pkg::operand_t got,
                                 inout bit ok);
        check_field(name, {label, ".ready"}, 32'(rdy), 32'(got.ready), ok);
        if (rdy) begin
            check_field(name, {label, ".value"}, word, got.word.value, ok);
        end else begin
            check_field(name, {label, ".tag"}, word, 32'(got.word.pend.tag), ok);
            check_field(name, {label, ".pad"}, 32'd0, 32'(got.word.pend.pad), ok);
        end
    endtask

    task automatic check_dispatch(input logic [2:0] tag, input logic rdy1,
                                  input logic [31:0] word1, input logic rdy2,
                                  input logic [31:0] word2);
        string                  name;
        rename_pkg::dispatch_t  got;
        rename_pkg::issue_req_t exp;
        bit                     ok;
        int                     n;
        test_num++;
        name = $sformatf("dispatch_%0d", test_num);
        ok = 1'b1;
        n = 0;
        while (dispatch_seen.size() == 0 && n < wait_limit) begin
            @(posedge clk);
            n++;
        end
        assert (dispatch_seen.size() != 0) else begin
            $display("%s: no dispatch packet arrived within %0d cycles", name, wait_limit);
            ok = 1'b0;
            timed_out = 1'b1;
        end
        if (ok) begin
            got = dispatch_seen.pop_front();
            exp = issued_q.pop_front();
            check_field(name, "kind", 32'(exp.kind), 32'(got.kind), ok);
            check_field(name, "rd", 32'(exp.rd), 32'(got.rd), ok);
            check_field(name, "imm", exp.imm, got.imm, ok);
            check_field(name, "pc", exp.pc, got.pc, ok);
            check_field(name, "dest_tag", 32'(tag), 32'(got.dest_tag), ok);
            check_operand(name, "src1", rdy1, word1, got.src1, ok);
            check_operand(name, "src2", rdy2, word2, got.src2, ok);
        end
        finish_test(name, ok);
    endtask

    task automatic check_commit(input logic [4:0] rd, input logic [31:0] data);
        string               name;
        rename_pkg::commit_t got;
        bit                  ok;
        int                  n;
        test_num++;
        name = $sformatf("commit_%0d", test_num);
        ok = 1'b1;
        n = 0;
        while (commit_seen.size() == 0 && n < wait_limit) begin
            @(posedge clk);
            n++;
        end
        assert (commit_seen.size() != 0) else begin
            $display("%s: no commit arrived within %0d cycles", name, wait_limit);
            ok = 1'b0;
            timed_out = 1'b1;
        end
        if (ok) begin
            got = commit_seen.pop_front();
            check_field(name, "rd", 32'(rd), 32'(got.rd), ok);
            check_field(name, "data", data, got.data, ok);
        end
        finish_test(name, ok);
    endtask

    task automatic check_ready(input logic expected);
        string name;
        bit    ok;
        test_num++;
        name = $sformatf("ready_%0d", test_num);
        ok = 1'b1;
        @(negedge clk);
        check_field(name, "issue_ready", 32'(expected), 32'(issue_ready), ok);
        finish_test(name, ok);
    endtask

    // ##############################
    // stimulus
    // ##############################

    function automatic rename_pkg::op_kind_e kind_of(input logic [8*16-1:0] kind_name);
        case (kind_name)
            "load":   return rename_pkg::op_load;
            "store":  return rename_pkg::op_store;
            "branch": return rename_pkg::op_branch;
            default:  return rename_pkg::op_alu;
        endcase
    endfunction

    // holds the request until issue_ready lets it through
    task automatic issue_op(input rename_pkg::op_kind_e kind, input logic [4:0] rd,
                            input logic [4:0] rs1, input logic [4:0] rs2);
        rename_pkg::issue_req_t req;
        int                     n;
        req.kind = kind;
        req.rd   = rd;
        req.rs1  = rs1;
        req.rs2  = rs2;
        req.imm  = $random(seed);
        req.pc   = $random(seed);
        n = 0;
        @(posedge clk);
        issue_valid <= 1'b1;
        issue_req   <= req;
        @(negedge clk);
        while (!issue_ready && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        assert (issue_ready) else begin
            $display("issue to rd %0d was never accepted, issue_ready stayed low", rd);
            failed++;
            timed_out = 1'b1;
        end
        @(posedge clk);
        issue_valid <= 1'b0;
        issued_q.push_back(req);
    endtask

    task automatic send_result(input logic [2:0] tag, input logic [31:0] data);
        @(posedge clk);
        result_valid <= 1'b1;
        result       <= '{tag: tag, data: data};
        @(posedge clk);
        result_valid <= 1'b0;
    endtask

    task automatic send_credit();
        @(posedge clk);
        credit_return <= 1'b1;
        @(posedge clk);
        credit_return <= 1'b0;
    endtask

    task automatic send_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    initial begin
        logic [8*16-1:0]  cmd;
        logic [8*16-1:0]  kind_name;
        logic [8*128-1:0] rest;
        logic [31:0]      f1;
        logic [31:0]      f2;
        logic [31:0]      f3;
        logic [31:0]      f4;
        logic [31:0]      f5;
        int               fd;
        int               code;
        rst           = 1'b1;
        issue_valid   = 1'b0;
        issue_req     = '0;
        credit_return = 1'b0;
        result_valid  = 1'b0;
        result        = '0;
        flush         = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("dv/rename_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/rename_cases.txt");
            failed++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                code = $fscanf(fd, "%s", cmd);
                if (code == 1) begin
                    case (cmd)
                        "#": code = $fgets(rest, fd);
                        "issue": begin
                            code = $fscanf(fd, "%s %h %h %h", kind_name, f1, f2, f3);
                            issue_op(kind_of(kind_name), f1[4:0], f2[4:0], f3[4:0]);
                        end
                        "result": begin
                            code = $fscanf(fd, "%h %h", f1, f2);
                            send_result(f1[2:0], f2);
                        end
                        "credit": send_credit();
                        "flush": send_flush();
                        "expect_dispatch": begin
                            code = $fscanf(fd, "%h %h %h %h %h", f1, f2, f3, f4, f5);
                            check_dispatch(f1[2:0], f2[0], f3, f4[0], f5);
                        end
                        "expect_commit": begin
                            code = $fscanf(fd, "%h %h", f1, f2);
                            check_commit(f1[4:0], f2);
                        end
                        "expect_ready": begin
                            code = $fscanf(fd, "%h", f1);
                            check_ready(f1[0]);
                        end
                        default: begin
                            $display("unknown command in the case file");
                            failed++;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end

        repeat (4) @(posedge clk);
        assert (commit_seen.size() == 0 && dispatch_seen.size() == 0) else begin
            $display("%0d commits and %0d dispatches came out that no case expected",
                     commit_seen.size(), dispatch_seen.size());
            failed++;
        end
        $display("%0d tests passed, %0d failed", passed, failed);
        if (failed == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: dv/rename_cases.txt
# issue kind rd rs1 rs2 | result tag data | credit | flush | all numbers hex
# expect_dispatch tag rdy1 word1 rdy2 word2 | expect_commit rd data | expect_ready bit
# reset state, tags in sequence
issue alu 1 5 6
expect_dispatch 0 1 0 1 0
issue alu 2 1 0
expect_dispatch 1 0 0 1 0
credit
credit
# done entry forwards, results out of order
result 1 22
issue alu 3 2 1
expect_dispatch 2 1 22 0 0
result 0 11
expect_commit 1 11
expect_commit 2 22
credit
issue alu 4 1 2
expect_dispatch 3 1 11 1 22
# store and branch leave the writer's tag
issue store 4 3 0
expect_dispatch 4 0 2 1 0
issue branch 3 4 0
expect_dispatch 5 0 3 1 0
credit
credit
credit
result 3 44
issue alu 5 4 3
expect_dispatch 6 1 44 0 2
result 2 33
expect_commit 3 33
expect_commit 4 44
credit
# credits run out, then the reorder buffer fills
issue alu 6 0 0
issue alu 7 0 0
issue alu 8 0 0
issue alu 9 0 0
expect_ready 0
credit
expect_ready 1
issue alu a 0 0
credit
credit
expect_ready 0
result 4 55
expect_commit 4 55
expect_ready 1
expect_dispatch 7 1 0 1 0
expect_dispatch 0 1 0 1 0
expect_dispatch 1 1 0 1 0
expect_dispatch 2 1 0 1 0
expect_dispatch 3 1 0 1 0
# flush drops pending tags, tags restart at 0
result 6 66
flush
issue alu b 5 4
expect_dispatch 0 1 0 1 55
issue alu c 3 b
expect_dispatch 1 1 33 0 0
result 0 77
expect_commit b 77

// File: src.f
design/rename_pkg.sv
design/issue_ctrl.sv
design/rename_regfile.sv
design/reorder_buffer.sv
design/issue_unit.sv
dv/issue_unit_tb.sv
